// File: rom_loader.f
+incdir+logic
logic/rom_loader_pkg.sv
logic/loader_write_if.sv
logic/rom_read_if.sv
logic/rom_region_decode.sv
logic/rom_bank_store.sv
logic/rom_read_select.sv
logic/rom_loader.sv
dv/tb_clock.sv
dv/rom_loader_tb.sv

// File: Bender.yml
package:
  name: rom_loader

export_include_dirs:
  - logic

sources:
  # RTL in compile order
  - logic/rom_loader_pkg.sv
  - logic/loader_write_if.sv
  - logic/rom_read_if.sv
  - logic/rom_region_decode.sv
  - logic/rom_bank_store.sv
  - logic/rom_read_select.sv
  - logic/rom_loader.sv

  # Testbench
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/rom_loader_tb.sv

// File: dv/rom_loader_tb.sv
`timescale 1ns/10ps
`include "rom_loader_cfg.svh"

module rom_loader_tb;
	import rom_loader_pkg::*;

	localparam int PERIOD_NS      = 40;
	localparam int WORDS_PER_BANK = 8;
	localparam int AUDIO_PER_BANK = 8;
	// Stimulus length in cycles
	localparam int STIM_CYCLES    = 8 * (`PROG_BANK_COUNT * WORDS_PER_BANK + 2 * AUDIO_PER_BANK)
		+ 4 * `DIP_COUNT + 50;
	localparam int MARGIN_CYCLES  = 200;

	// Program bank bases on the download and CPU sides
	localparam dl_addr_t DL_BASE [`PROG_BANK_COUNT] = '{
		`BASE_9A_9B, `BASE_10A_10B, `BASE_7A_7B, `BASE_6A_6B, `BASE_5A_5B, `BASE_3A_3B
	};
	localparam prog_addr_t CPU_BASE [`PROG_BANK_COUNT] = '{
		19'h00000, 19'h18000, 19'h20000, 19'h28000, 19'h30000, 19'h38000
	};

	logic        clk_sys;
	logic        rst;
	logic        ioctl_download;
	logic        ioctl_wr;
	dl_index_t   ioctl_index;
	dl_addr_t    ioctl_addr;
	byte_t       ioctl_dout;
	prog_addr_t  prog_addr;
	audio_addr_t audio_addr;
	prog_word_t  prog_data;
	byte_t       audio_data;
	byte_t       game_type;
	dip_bits_t   dip_switches;

	logic [31:0] lfsr;
	int          errors = 0;
	int          reads = 0;

	// Read checks driven with the address and delayed one edge
	logic        prog_chk;
	prog_word_t  prog_exp;
	logic        prog_pending;
	prog_word_t  prog_expect;
	prog_addr_t  prog_addr_q;
	logic        audio_chk;
	byte_t       audio_exp;
	logic        audio_pending;
	byte_t       audio_expect;
	audio_addr_t audio_addr_q;

	// Reference model
	prog_word_t  prog_model [int];   // By CPU word address
	byte_t       audio_model [int];  // By audio CPU address
	int          wr_bank [$];
	int          wr_word [$];
	int          au_bank [$];
	int          au_off [$];
	byte_t       exp_game_type;
	dip_bits_t   exp_dip;

	tb_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(2)) tb_clock_inst (
		.clk_sys (clk_sys),
		.rst     (rst)
	);

	rom_loader rom_loader_inst (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.prog_addr      (prog_addr),
		.audio_addr     (audio_addr),
		.prog_data      (prog_data),
		.audio_data     (audio_data),
		.game_type      (game_type),
		.dip_switches   (dip_switches)
	);

	// ########################################
	// Read data checks
	// ########################################
	always @(posedge clk_sys) begin
		prog_pending  <= prog_chk;
		prog_expect   <= prog_exp;
		prog_addr_q   <= prog_addr;
		audio_pending <= audio_chk;
		audio_expect  <= audio_exp;
		audio_addr_q  <= audio_addr;
	end

	prog_read_check: assert property (@(posedge clk_sys) disable iff (rst)
		prog_pending |-> prog_data == prog_expect)
	else begin
		errors++;
		$display("ERROR at %0t: prog_data (addr %h) expected %h, got %h", $time,
			$sampled(prog_addr_q), $sampled(prog_expect), $sampled(prog_data));
	end

	audio_read_check: assert property (@(posedge clk_sys) disable iff (rst)
		audio_pending |-> audio_data == audio_expect)
	else begin
		errors++;
		$display("ERROR at %0t: audio_data (addr %h) expected %h, got %h", $time,
			$sampled(audio_addr_q), $sampled(audio_expect), $sampled(audio_data));
	end

	// Galois LFSR with one step per bit
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// ########################################
	// Stimulus tasks
	// ########################################
	task automatic send_byte(input dl_index_t idx, input dl_addr_t a, input byte_t d,
		input logic dl);
		@(negedge clk_sys);
		ioctl_download = dl;
		ioctl_index    = idx;
		ioctl_addr     = a;
		ioctl_dout     = d;
		ioctl_wr       = 1'b1;  // Back to back at full rate
	endtask

	task automatic stop_writes(input int n);
		repeat (n) begin
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
		end
	endtask

	// Even byte is the high byte
	task automatic write_word(input int b, input int w, input prog_word_t v);
		send_byte(`ROM_INDEX, DL_BASE[b] + dl_addr_t'(2 * w), v[15:8], 1'b1);
		send_byte(`ROM_INDEX, DL_BASE[b] + dl_addr_t'(2 * w + 1), v[7:0], 1'b1);
		prog_model[int'(CPU_BASE[b]) + w] = v;
		wr_bank.push_back(b);
		wr_word.push_back(w);
	endtask

	task automatic write_audio(input int ab, input int off, input byte_t v);
		send_byte(`ROM_INDEX, (ab == 0 ? `BASE_16S : `BASE_16R) + dl_addr_t'(off), v, 1'b1);
		audio_model[ab == 0 ? 32'h8000 + off : off] = v;  // 16S reads with bit 15 set
		au_bank.push_back(ab);
		au_off.push_back(off);
	endtask

	task automatic read_prog(input prog_addr_t a, input prog_word_t e);
		@(negedge clk_sys);
		prog_addr = a;
		prog_exp  = e;
		prog_chk  = 1'b1;
		reads++;
	endtask

	task automatic read_audio(input audio_addr_t a, input byte_t e);
		@(negedge clk_sys);
		audio_addr = a;
		audio_exp  = e;
		audio_chk  = 1'b1;
		reads++;
	endtask

	// Let the last checks in flight finish
	task automatic stop_reads();
		@(negedge clk_sys);
		prog_chk  = 1'b0;
		audio_chk = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic read_all();
		foreach (prog_model[a]) read_prog(prog_addr_t'(a), prog_model[a]);
		@(negedge clk_sys);
		prog_chk = 1'b0;  // Last program read still in flight
		foreach (audio_model[a]) read_audio(audio_addr_t'(a), audio_model[a]);
		stop_reads();
	endtask

	task automatic check_settings();
		@(negedge clk_sys);
		assert (game_type == exp_game_type) else begin
			errors++;
			$display("ERROR at %0t: game_type expected %h, got %h", $time,
				exp_game_type, game_type);
		end
		assert (dip_switches == exp_dip) else begin
			errors++;
			$display("ERROR at %0t: dip_switches expected %h, got %h", $time,
				exp_dip, dip_switches);
		end
	endtask

	task automatic report();
		$display("Summary: %0d reads checked, %0d errors", reads, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	endtask

	// ########################################
	// Test sequence
	// ########################################
	initial begin
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		prog_addr      = '0;
		audio_addr     = '0;
		prog_chk       = 1'b0;
		prog_exp       = '0;
		audio_chk      = 1'b0;
		audio_exp      = '0;
		lfsr           = 32'h8c261a15;
		exp_game_type  = `GAME_TYPE_RESET;
		exp_dip        = '0;

		wait (!rst);
		check_settings();  // Reset values

		// Random image with the top word of each bank included
		for (int b = 0; b < `PROG_BANK_COUNT; b++) begin
			for (int k = 0; k < WORDS_PER_BANK; k++) begin
				write_word(b, k == 0 ? `PROG_DEPTH(b) - 1 : int'(take_bits(14)), take_bits(16));
			end
		end
		for (int k = 0; k < AUDIO_PER_BANK; k++) begin
			write_audio(`AUDIO_BANK_16S, take_bits(15), take_bits(8));
			write_audio(`AUDIO_BANK_16R, take_bits(14), take_bits(8));
		end
		stop_writes(3);  // Memory lands two edges after the byte
		read_all();

		// Filler and download-low writes aliased onto written locations
		foreach (wr_bank[i]) begin
			dl_addr_t pair;
			pair = dl_addr_t'(2 * wr_word[i]);
			send_byte(`ROM_INDEX, DL_BASE[wr_bank[i]] + pair, take_bits(8), 1'b0);
			send_byte(`ROM_INDEX, DL_BASE[wr_bank[i]] + pair + 1, take_bits(8), 1'b0);
			if (wr_bank[i] == `BANK_9A_9B) begin
				send_byte(`ROM_INDEX, 25'h0D0000 + pair, take_bits(8), 1'b1);
				send_byte(`ROM_INDEX, 25'h0D0001 + pair, take_bits(8), 1'b1);
			end
			if (wr_bank[i] == `BANK_10A_10B) begin
				send_byte(`ROM_INDEX, 25'h0F8000 + pair, take_bits(8), 1'b1);
				send_byte(`ROM_INDEX, 25'h0F8001 + pair, take_bits(8), 1'b1);
			end
		end
		foreach (au_bank[i]) begin
			send_byte(`ROM_INDEX, `BASE_16S + dl_addr_t'(au_off[i]), take_bits(8), 1'b0);
			if (au_bank[i] == `AUDIO_BANK_16R) begin
				send_byte(`ROM_INDEX, 25'h14C000 + dl_addr_t'(au_off[i]), take_bits(8), 1'b1);
			end
		end
		stop_writes(3);
		read_all();

		// Gaps between banks and the upper space, each aliasing a written top word
		read_prog(19'h0FFFF, '0);
		read_prog(19'h17FFF, '0);
		read_prog(19'h1FFFF, '0);
		read_prog(19'h47FFF, '0);
		read_prog(19'h7FFFF, '0);
		stop_reads();

		// Game type and DIP bytes
		exp_game_type = take_bits(8);
		send_byte(`GAME_TYPE_INDEX, '0, exp_game_type, 1'b1);
		for (int i = 0; i < `DIP_COUNT; i++) begin
			exp_dip[i*8 +: 8] = take_bits(8);
			send_byte(`DIP_INDEX, dl_addr_t'(i), exp_dip[i*8 +: 8], 1'b1);
		end
		send_byte(`DIP_INDEX, 25'd8, take_bits(8), 1'b1);  // Past the last DIP byte
		send_byte(`DIP_INDEX, 25'd200, take_bits(8), 1'b1);
		stop_writes(2);
		check_settings();

		report();
	end

	// Watchdog
	initial begin
		#((STIM_CYCLES + MARGIN_CYCLES) * PERIOD_NS);
		$display("Timeout: test sequence did not finish within %0d cycles",
			STIM_CYCLES + MARGIN_CYCLES);
		errors++;
		report();
	end

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 2
) (
	output logic clk_sys,
	output logic rst
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	// Reset over the first rising edges, released on a falling edge
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		rst = 1'b0;
	end

endmodule

// File: logic/rom_loader.sv
`timescale 1ns/10ps

module rom_loader (
	input  logic                        clk_sys,
	input  logic                        rst,

	// Download stream
	input  logic                        ioctl_download,
	input  logic                        ioctl_wr,       // One strobe per byte
	input  rom_loader_pkg::dl_index_t   ioctl_index,
	input  rom_loader_pkg::dl_addr_t    ioctl_addr,
	input  rom_loader_pkg::byte_t       ioctl_dout,

	// CPU read ports
	input  rom_loader_pkg::prog_addr_t  prog_addr,
	input  rom_loader_pkg::audio_addr_t audio_addr,
	output rom_loader_pkg::prog_word_t  prog_data,      // One cycle after address
	output rom_loader_pkg::byte_t       audio_data,

	// Settings
	output rom_loader_pkg::byte_t       game_type,
	output rom_loader_pkg::dip_bits_t   dip_switches
);

	loader_write_if wr_bus ();
	rom_read_if     rd_bus ();

	// Stream to bank writes
	rom_region_decode rom_region_decode_inst (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.game_type      (game_type),
		.dip_switches   (dip_switches),
		.wr_bus         (wr_bus)
	);

	// Program and audio memories
	rom_bank_store rom_bank_store_inst (
		.clk_sys (clk_sys),
		.rst     (rst),
		.wr_bus  (wr_bus),
		.rd_bus  (rd_bus)
	);

	// CPU address map
	rom_read_select rom_read_select_inst (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.prog_addr  (prog_addr),
		.audio_addr (audio_addr),
		.prog_data  (prog_data),
		.audio_data (audio_data),
		.rd_bus     (rd_bus)
	);

endmodule

// File: logic/rom_read_select.sv
`timescale 1ns/10ps
`include "rom_loader_cfg.svh"

module rom_read_select (
	input  logic                        clk_sys,
	input  logic                        rst,
	input  rom_loader_pkg::prog_addr_t  prog_addr,
	input  rom_loader_pkg::audio_addr_t audio_addr,
	output rom_loader_pkg::prog_word_t  prog_data,
	output rom_loader_pkg::byte_t       audio_data,
	rom_read_if.select                  rd_bus
);
	import rom_loader_pkg::*;

	bank_id_t bank_sel;   // Decoded bank
	logic     mapped;     // Address lands in a bank
	bank_id_t bank_q;
	logic     mapped_q;
	logic     audio_hi_q; // Audio bit 15, delayed

	// Low bits go to every bank, each takes what it needs
	assign rd_bus.prog_offset  = prog_addr[14:0];
	assign rd_bus.audio_offset = audio_addr[14:0];

	// Program address map
	always_comb begin
		mapped   = 1'b1;
		bank_sel = bank_id_t'(`BANK_9A_9B);
		if (prog_addr[18:15] == 4'b0000) begin
			bank_sel = bank_id_t'(`BANK_9A_9B);
		end else if (prog_addr[18:14] == 5'b00110) begin
			bank_sel = bank_id_t'(`BANK_10A_10B);
		end else if (prog_addr[18:17] == 2'b01) begin
			// 0100..0111 give 7A, 6A, 5A, 3A in order
			bank_sel = bank_id_t'(`BANK_7A_7B) + bank_id_t'(prog_addr[16:15]);
		end else begin
			mapped = 1'b0;  // Gaps and upper space
		end
	end

	// Line the choice up with the memory read register
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			bank_q     <= '0;
			mapped_q   <= 1'b0;
			audio_hi_q <= 1'b0;
		end else begin
			bank_q     <= bank_sel;
			mapped_q   <= mapped;
			audio_hi_q <= audio_addr[15];
		end
	end

	assign prog_data  = mapped_q ? rd_bus.prog_bank_data[bank_q] : '0;
	assign audio_data = audio_hi_q ? rd_bus.audio_16s_data : rd_bus.audio_16r_data;

endmodule

// File: logic/rom_bank_store.sv
`timescale 1ns/10ps
`include "rom_loader_cfg.svh"

module rom_bank_store (
	input logic          clk_sys,
	input logic          rst,
	loader_write_if.sink wr_bus,
	rom_read_if.memory   rd_bus
);
	import rom_loader_pkg::*;

	byte_t hi_byte;     // Even byte waiting for its partner
	logic  even_we;     // High byte of a program word
	logic  prog_we;     // Low byte, word complete
	byte_t audio_q [2]; // Audio read registers, 16S then 16R

	assign even_we = wr_bus.wr && !wr_bus.to_audio && !wr_bus.odd;
	assign prog_we = wr_bus.wr && !wr_bus.to_audio && wr_bus.odd;

	always_ff @(posedge clk_sys) begin
		if (even_we) begin
			hi_byte <= wr_bus.data;
		end
	end

	// ########################################
	// Program banks
	// ########################################
	for (genvar b = 0; b < `PROG_BANK_COUNT; b++) begin : g_prog
		localparam int DEPTH = `PROG_DEPTH(b);
		localparam int AW    = $clog2(DEPTH);  // 14 for 10A/10B

		prog_word_t mem [DEPTH];
		prog_word_t rd_q;

		// Big endian pair, even byte on top
		always_ff @(posedge clk_sys) begin
			if (prog_we && wr_bus.bank == bank_id_t'(b)) begin
				mem[wr_bus.offset[AW-1:0]] <= {hi_byte, wr_bus.data};
			end
		end

		always_ff @(posedge clk_sys) begin
			if (rst) begin
				rd_q <= '0;
			end else begin
				rd_q <= mem[rd_bus.prog_offset[AW-1:0]];  // One cycle latency
			end
		end

		assign rd_bus.prog_bank_data[b] = rd_q;
	end

	// ########################################
	// Audio banks
	// ########################################
	for (genvar a = 0; a < 2; a++) begin : g_audio
		localparam int DEPTH = `AUDIO_DEPTH(a);
		localparam int AW    = $clog2(DEPTH);

		byte_t mem [DEPTH];
		logic  we;

		assign we = wr_bus.wr && wr_bus.to_audio && wr_bus.bank == bank_id_t'(a);

		// Bytes go straight in, no pairing
		always_ff @(posedge clk_sys) begin
			if (we) begin
				mem[wr_bus.offset[AW-1:0]] <= wr_bus.data;
			end
		end

		always_ff @(posedge clk_sys) begin
			if (rst) begin
				audio_q[a] <= '0;
			end else begin
				audio_q[a] <= mem[rd_bus.audio_offset[AW-1:0]];
			end
		end
	end

	assign rd_bus.audio_16s_data = audio_q[`AUDIO_BANK_16S];
	assign rd_bus.audio_16r_data = audio_q[`AUDIO_BANK_16R];

endmodule

// File: logic/rom_region_decode.sv
`timescale 1ns/10ps
`include "rom_loader_cfg.svh"

module rom_region_decode (
	input  logic                      clk_sys,
	input  logic                      rst,
	input  logic                      ioctl_download,
	input  logic                      ioctl_wr,
	input  rom_loader_pkg::dl_index_t ioctl_index,
	input  rom_loader_pkg::dl_addr_t  ioctl_addr,
	input  rom_loader_pkg::byte_t     ioctl_dout,
	output rom_loader_pkg::byte_t     game_type,
	output rom_loader_pkg::dip_bits_t dip_switches,
	loader_write_if.source            wr_bus
);
	import rom_loader_pkg::*;

	localparam int DIP_SEL_W = $clog2(`DIP_COUNT);

	// Program region bases, in bank number order
	localparam dl_addr_t PROG_BASE [`PROG_BANK_COUNT] = '{
		`BASE_9A_9B, `BASE_10A_10B, `BASE_7A_7B,
		`BASE_6A_6B, `BASE_5A_5B, `BASE_3A_3B
	};

	logic         rom_wr;      // ROM byte this cycle
	logic         hit;         // Address inside a real bank
	logic         hit_audio;
	bank_id_t     hit_bank;
	bank_offset_t hit_offset;

	assign rom_wr = ioctl_wr && ioctl_download && (ioctl_index == `ROM_INDEX);

	// ########################################
	// Region compare
	// ########################################
	always_comb begin
		dl_addr_t rel;

		hit        = 1'b0;
		hit_audio  = 1'b0;
		hit_bank   = '0;
		hit_offset = '0;
		rel        = '0;

		// Program regions hold byte pairs, so twice the word depth
		for (int i = 0; i < `PROG_BANK_COUNT; i++) begin
			rel = ioctl_addr - PROG_BASE[i];
			if (ioctl_addr >= PROG_BASE[i] && rel < dl_addr_t'(2 * `PROG_DEPTH(i))) begin
				hit        = 1'b1;
				hit_bank   = bank_id_t'(i);
				hit_offset = rel[15:1];  // Word index
			end
		end

		// Audio regions, one byte per location
		rel = ioctl_addr - `BASE_16S;
		if (ioctl_addr >= `BASE_16S && rel < dl_addr_t'(`AUDIO_DEPTH_16S)) begin
			hit        = 1'b1;
			hit_audio  = 1'b1;
			hit_bank   = bank_id_t'(`AUDIO_BANK_16S);
			hit_offset = rel[14:0];
		end
		rel = ioctl_addr - `BASE_16R;
		if (ioctl_addr >= `BASE_16R && rel < dl_addr_t'(`AUDIO_DEPTH_16R)) begin
			hit        = 1'b1;
			hit_audio  = 1'b1;
			hit_bank   = bank_id_t'(`AUDIO_BANK_16R);
			hit_offset = rel[14:0];
		end
	end

	// ########################################
	// Write bus register
	// ########################################
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr_bus.wr <= 1'b0;
		end else begin
			wr_bus.wr <= rom_wr && hit;  // Filler and out of range drop here
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rom_wr && hit) begin
			wr_bus.to_audio <= hit_audio;
			wr_bus.bank     <= hit_bank;
			wr_bus.offset   <= hit_offset;
			wr_bus.data     <= ioctl_dout;
			wr_bus.odd      <= ioctl_addr[0];  // Odd address is the low byte
		end
	end

	// Game type and DIP bytes, any download state
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			game_type    <= `GAME_TYPE_RESET;
			dip_switches <= '0;
		end else if (ioctl_wr) begin
			if (ioctl_index == `GAME_TYPE_INDEX) begin
				game_type <= ioctl_dout;
			end
			if (ioctl_index == `DIP_INDEX && ioctl_addr < dl_addr_t'(`DIP_COUNT)) begin
				dip_switches[ioctl_addr[DIP_SEL_W-1:0]*8 +: 8] <= ioctl_dout;
			end
		end
	end

endmodule

// File: logic/rom_read_if.sv
`timescale 1ns/10ps
`include "rom_loader_cfg.svh"

// Read addresses out to the memories, raw bank data back
interface rom_read_if;
	import rom_loader_pkg::*;

	bank_offset_t prog_offset;   // Same offset to every program bank
	bank_offset_t audio_offset;  // Same offset to both audio banks

	prog_word_t   prog_bank_data [`PROG_BANK_COUNT];  // One word per bank
	byte_t        audio_16s_data;
	byte_t        audio_16r_data;

	// Store side
	modport memory (
		input  prog_offset, audio_offset,
		output prog_bank_data, audio_16s_data, audio_16r_data
	);

	// Select side
	modport select (
		output prog_offset, audio_offset,
		input  prog_bank_data, audio_16s_data, audio_16r_data
	);

endinterface

// File: logic/loader_write_if.sv
`timescale 1ns/10ps

// One decoded ROM write, no handshake
interface loader_write_if;
	import rom_loader_pkg::*;

	logic         wr;        // One cycle per write
	logic         to_audio;  // Audio side, else program side
	bank_id_t     bank;      // Program bank, or 16S/16R on audio
	bank_offset_t offset;    // Word index on program, byte on audio
	byte_t        data;
	logic         odd;       // Low byte of a program word

	modport source (
		output wr, to_audio, bank, offset, data, odd
	);

	modport sink (
		input wr, to_audio, bank, offset, data, odd
	);

endinterface

// File: logic/rom_loader_pkg.sv
package rom_loader_pkg;

	// Download stream
	typedef logic [7:0]  byte_t;      // Download or audio byte
	typedef logic [24:0] dl_addr_t;   // Download address
	typedef logic [7:0]  dl_index_t;  // Download index

	// CPU program side
	typedef logic [15:0] prog_word_t;  // Program ROM word, high byte first
	typedef logic [18:0] prog_addr_t;  // CPU word address

	// Audio CPU side
	typedef logic [15:0] audio_addr_t;

	// Bank addressing
	// Program bank 0 to 5, or audio 16S/16R on the audio side
	typedef logic [2:0]  bank_id_t;
	// Word offset for program, byte offset for audio
	typedef logic [14:0] bank_offset_t;

	// All eight DIP bytes, byte 0 in the low bits
	typedef logic [63:0] dip_bits_t;

endpackage

// File: logic/rom_loader_cfg.svh
`ifndef ROM_LOADER_CFG_SVH
`define ROM_LOADER_CFG_SVH

// ########################################
// Download indices
// ########################################
`define ROM_INDEX        8'd0    // ROM images
`define GAME_TYPE_INDEX  8'd1    // Game type byte
`define DIP_INDEX        8'd254  // DIP switch bytes

`define DIP_COUNT        8
`define GAME_TYPE_RESET  8'd104  // Gauntlet

// ########################################
// Bank geometry
// ########################################
`define PROG_BANK_COUNT  6
`define PROG_DEPTH_LARGE 32768   // Words
`define PROG_DEPTH_SMALL 16384   // Words, 10A/10B only
`define AUDIO_DEPTH_16S  32768   // Bytes
`define AUDIO_DEPTH_16R  16384   // Bytes

// Program bank numbers
`define BANK_9A_9B       0
`define BANK_10A_10B     1
`define BANK_7A_7B       2
`define BANK_6A_6B       3
`define BANK_5A_5B       4
`define BANK_3A_3B       5

// Audio bank numbers on the write bus
`define AUDIO_BANK_16S   0
`define AUDIO_BANK_16R   1

// Word depth per program bank
`define PROG_DEPTH(b)  ((b) == `BANK_10A_10B ? `PROG_DEPTH_SMALL : `PROG_DEPTH_LARGE)
// Byte depth per audio bank
`define AUDIO_DEPTH(a) ((a) == `AUDIO_BANK_16R ? `AUDIO_DEPTH_16R : `AUDIO_DEPTH_16S)

// ########################################
// Region bases in download space
// ########################################
`define BASE_9A_9B       25'h0C0000
`define BASE_10A_10B     25'h0F0000  // 0F8000..0FFFFF is filler
`define BASE_7A_7B       25'h100000
`define BASE_6A_6B       25'h110000
`define BASE_5A_5B       25'h120000
`define BASE_3A_3B       25'h130000
`define BASE_16S         25'h140000
`define BASE_16R         25'h148000

`endif
